// File: compile.f
+incdir+bench
design/vec_isa_pkg.sv
design/vec_lane_pkg.sv
design/vec_ifs.sv
design/vec_regfile.sv
design/vec_decode.sv
design/element_counter.sv
design/vec_execute.sv
design/vec_writeback.sv
design/vector_unit.sv
bench/vector_unit_tb.sv

// File: Bender.yml
package:
  name: vector_unit

sources:
  - files:
      - design/vec_isa_pkg.sv
      - design/vec_lane_pkg.sv
      - design/vec_ifs.sv
      - design/vec_regfile.sv
      - design/vec_decode.sv
      - design/element_counter.sv
      - design/vec_execute.sv
      - design/vec_writeback.sv
      - design/vector_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/vector_unit_tb.sv

// File: bench/vec_model.svh
// vector unit reference model
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

// model copy of the register file
vec_lane_pkg::elem_t   model_regs [NUM_VREGS][MAX_VL];

// expected report stream, one entry per group
vec_lane_pkg::offset_t exp_offset [$];
vec_lane_pkg::vreg_t   exp_vd [$];
logic [NUM_LANES-1:0]  exp_mask [$];
logic [DATA_W-1:0]     exp_data [$];
bit                    exp_last [$];

function automatic void model_reset();
  for (int v = 0; v < NUM_VREGS; v++) begin
    for (int e = 0; e < MAX_VL; e++) begin
      model_regs[v][e] = '0;
    end
  end
endfunction

// past the register end reads as zero
function automatic vec_lane_pkg::elem_t model_read(input vec_lane_pkg::vreg_t r,
                                                   input vec_lane_pkg::offset_t idx);
  if (idx < MAX_VL) begin
    return model_regs[r][idx];
  end
  return '0;
endfunction

// queue every group of one instruction, from vstart until offset plus lanes reaches vl
function automatic void predict_groups(input vec_isa_pkg::vop_t op,
                                       input vec_lane_pkg::vreg_t vd, vs1, vs2,
                                       input vec_lane_pkg::elem_t scal,
                                       input vec_lane_pkg::offset_t len, first);
  vec_lane_pkg::offset_t off;
  vec_lane_pkg::offset_t idx;
  vec_lane_pkg::elem_t   a;
  vec_lane_pkg::elem_t   b;
  vec_lane_pkg::elem_t   r;
  logic [NUM_LANES-1:0]  mask;
  logic [DATA_W-1:0]     data;
  bit                    last;
  off  = first;
  last = 1'b0;
  while (!last) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = off + i;
      a   = model_read(vs1, idx);
      b   = model_read(vs2, idx);
      case (op)
        vec_isa_pkg::VADD_VV: r = a + b;
        vec_isa_pkg::VSUB_VV: r = a - b;
        vec_isa_pkg::VAND_VV: r = a & b;
        vec_isa_pkg::VXOR_VV: r = a ^ b;
        vec_isa_pkg::VADD_VX: r = scal + b;
        vec_isa_pkg::VMV_VX:  r = scal;
        vec_isa_pkg::VID_V:   r = idx;
        default:              r = '0;
      endcase
      // nop groups run but never write
      mask[i] = (idx < len) && (op != vec_isa_pkg::VNOP);
      data[i*vec_lane_pkg::ELEM_W +: vec_lane_pkg::ELEM_W] = r;
    end
    last = (off + NUM_LANES) >= len;
    exp_offset.push_back(off);
    exp_vd.push_back(vd);
    exp_mask.push_back(mask);
    exp_data.push_back(data);
    exp_last.push_back(last);
    off = off + NUM_LANES;
  end
endfunction

// model write of one reported group
function automatic void apply_group(input vec_lane_pkg::vreg_t vd,
                                    input vec_lane_pkg::offset_t off,
                                    input logic [NUM_LANES-1:0] mask,
                                    input logic [DATA_W-1:0] data);
  vec_lane_pkg::offset_t idx;
  for (int i = 0; i < NUM_LANES; i++) begin
    idx = off + i;
    if (mask[i] && idx < MAX_VL) begin
      model_regs[vd][idx] = data[i*vec_lane_pkg::ELEM_W +: vec_lane_pkg::ELEM_W];
    end
  end
endfunction

// groups cut off by an abort never arrive
function automatic void drop_expected();
  exp_offset.delete();
  exp_vd.delete();
  exp_mask.delete();
  exp_data.delete();
  exp_last.delete();
endfunction

`endif

// File: bench/vector_unit_tb.sv
// vector unit testbench
module vector_unit_tb;

  localparam int NUM_LANES = 2;
  localparam int MAX_VL    = 16;
  localparam int NUM_VREGS = 8;
  localparam int DATA_W    = NUM_LANES * vec_lane_pkg::ELEM_W;
  localparam int TIMEOUT   = 200;

  logic                            CLK;
  logic                            nRST;
  logic                            instr_valid;
  logic [vec_isa_pkg::INSTR_W-1:0] instr;
  vec_lane_pkg::elem_t             scalar;
  vec_lane_pkg::offset_t           vl;
  vec_lane_pkg::offset_t           vstart;
  logic                            stall;
  logic                            clear;
  logic                            busy;
  logic                            wb_valid;
  vec_lane_pkg::vreg_t             wb_vd;
  vec_lane_pkg::offset_t           wb_offset;
  logic [NUM_LANES-1:0]            wb_mask;
  logic [DATA_W-1:0]               wb_data;
  logic                            done;

  integer seed;
  bit     use_stall;
  bit     timed_out;
  bit     idle_due;
  int     mismatch_count;
  int     error_count;
  int     instr_count;
  int     report_count;
  int     done_count;

  `include "vec_model.svh"

  vector_unit #(
    .NUM_LANES (NUM_LANES),
    .MAX_VL    (MAX_VL),
    .NUM_VREGS (NUM_VREGS)
  ) vector_unit_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .scalar      (scalar),
    .vl          (vl),
    .vstart      (vstart),
    .stall       (stall),
    .clear       (clear),
    .busy        (busy),
    .wb_valid    (wb_valid),
    .wb_vd       (wb_vd),
    .wb_offset   (wb_offset),
    .wb_mask     (wb_mask),
    .wb_data     (wb_data),
    .done        (done)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic note_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    mismatch_count++;
  endtask

  task automatic note_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count++;
  endtask

  // one report against its expected group
  // lane data only where the lane is masked in
  task automatic check_group(input vec_lane_pkg::offset_t got_off, want_off,
                             input vec_lane_pkg::vreg_t got_vd, want_vd,
                             input logic [NUM_LANES-1:0] got_mask, want_mask,
                             input logic [DATA_W-1:0] got_data, want_data);
    vec_lane_pkg::elem_t got_e;
    vec_lane_pkg::elem_t want_e;
    if (got_off !== want_off) begin
      note_mismatch($sformatf("offset %0d, expected %0d", got_off, want_off));
    end
    if (got_vd !== want_vd) begin
      note_mismatch($sformatf("vd %0d, expected %0d", got_vd, want_vd));
    end
    if (got_mask !== want_mask) begin
      note_mismatch($sformatf("mask %b, expected %b at offset %0d", got_mask, want_mask,
                              want_off));
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      got_e  = got_data[i*vec_lane_pkg::ELEM_W +: vec_lane_pkg::ELEM_W];
      want_e = want_data[i*vec_lane_pkg::ELEM_W +: vec_lane_pkg::ELEM_W];
      if (want_mask[i] && got_e !== want_e) begin
        note_mismatch($sformatf("lane %0d at offset %0d is %h, expected %h", i, want_off,
                                got_e, want_e));
      end
    end
  endtask

  task automatic check_done(input logic got_done, want_done, got_busy, want_busy);
    if (got_done !== want_done) begin
      note_mismatch($sformatf("done %b, expected %b", got_done, want_done));
    end
    if (got_busy !== want_busy) begin
      note_mismatch($sformatf("busy %b, expected %b", got_busy, want_busy));
    end
  endtask

  // report monitor sampling mid cycle
  always @(negedge CLK) begin : monitor
    vec_lane_pkg::offset_t e_off;
    vec_lane_pkg::vreg_t   e_vd;
    logic [NUM_LANES-1:0]  e_mask;
    logic [DATA_W-1:0]     e_data;
    bit                    e_last;
    if (nRST) begin
      // cycle after the last report drops busy
      if (idle_due) begin
        check_done(done, 1'b0, busy, 1'b0);
        idle_due = 1'b0;
      end
      if (wb_valid) begin
        report_count++;
        if (exp_offset.size() == 0) begin
          note_error($sformatf("report at offset %0d with no group expected", wb_offset));
        end else begin
          e_off  = exp_offset.pop_front();
          e_vd   = exp_vd.pop_front();
          e_mask = exp_mask.pop_front();
          e_data = exp_data.pop_front();
          e_last = exp_last.pop_front();
          check_group(wb_offset, e_off, wb_vd, e_vd, wb_mask, e_mask, wb_data, e_data);
          check_done(done, e_last, busy, 1'b1);
          idle_due = e_last;
          // model follows only what was actually reported
          apply_group(e_vd, e_off, e_mask, e_data);
        end
      end else if (done) begin
        note_error("done raised without a report");
      end
      if (done) begin
        done_count++;
      end
    end
  end

  function automatic logic pick_stall();
    return use_stall && (($random(seed) & 3) == 0);
  endfunction

  function automatic logic [vec_isa_pkg::INSTR_W-1:0] encode_instr(
      input vec_isa_pkg::vop_t op, input vec_lane_pkg::vreg_t vd, vs1, vs2);
    logic [vec_isa_pkg::INSTR_W-1:0] w;
    w = '0;
    w[vec_isa_pkg::OP_MSB:vec_isa_pkg::OP_LSB]   = op;
    w[vec_isa_pkg::VD_MSB:vec_isa_pkg::VD_LSB]   = vd;
    w[vec_isa_pkg::VS1_MSB:vec_isa_pkg::VS1_LSB] = vs1;
    w[vec_isa_pkg::VS2_MSB:vec_isa_pkg::VS2_LSB] = vs2;
    return w;
  endfunction

  // one cycle strobe that returns in the start cycle
  task automatic send_instr(input vec_isa_pkg::vop_t op, input vec_lane_pkg::vreg_t vd, vs1, vs2,
                            input vec_lane_pkg::elem_t scal,
                            input vec_lane_pkg::offset_t len, first);
    @(posedge CLK);
    #1;
    predict_groups(op, vd, vs1, vs2, scal, len, first);
    instr_valid = 1'b1;
    instr       = encode_instr(op, vd, vs1, vs2);
    scalar      = scal;
    vl          = len;
    vstart      = first;
    stall       = pick_stall();
    @(posedge CLK);
    #1;
    instr_valid = 1'b0;
    stall       = pick_stall();
    instr_count++;
  endtask

  // random stall every cycle until the run drains
  task automatic wait_idle();
    int cycles;
    bit idle;
    cycles = 0;
    idle   = 1'b0;
    while (!idle && cycles < TIMEOUT) begin
      @(negedge CLK);
      if (!busy) begin
        idle = 1'b1;
      end else begin
        @(posedge CLK);
        #1;
        stall = pick_stall();
        cycles++;
      end
    end
    if (!idle) begin
      note_error("busy did not fall within 200 cycles");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_instr(input vec_isa_pkg::vop_t op, input vec_lane_pkg::vreg_t vd, vs1, vs2,
                           input vec_lane_pkg::elem_t scal,
                           input vec_lane_pkg::offset_t len, first);
    int done_before;
    if (timed_out) begin
      return;
    end
    done_before = done_count;
    send_instr(op, vd, vs1, vs2, scal, len, first);
    wait_idle();
    if (timed_out) begin
      return;
    end
    if (done_count != done_before + 1) begin
      note_mismatch($sformatf("done pulsed %0d times, expected once", done_count - done_before));
    end
    if (exp_offset.size() != 0) begin
      note_error($sformatf("%0d expected groups were never reported", exp_offset.size()));
      drop_expected();
    end
  endtask

  // abort a full length broadcast after two groups
  task automatic run_clear();
    int reports_before;
    int done_before;
    if (timed_out) begin
      return;
    end
    use_stall = 1'b0;
    send_instr(vec_isa_pkg::VMV_VX, 3'd5, 3'd0, 3'd0, 32'hdead_beef, MAX_VL, 0);
    repeat (2) @(posedge CLK);
    #1;
    reports_before = report_count;
    done_before    = done_count;
    clear          = 1'b1;
    @(posedge CLK);
    #1;
    clear = 1'b0;
    wait_idle();
    if (timed_out) begin
      return;
    end
    // at most the two groups already in the pipe
    if (report_count - reports_before > 2) begin
      note_error($sformatf("%0d groups reported after clear", report_count - reports_before));
    end
    if (exp_offset.size() == 0) begin
      note_error("clear did not cut the instruction short");
    end
    if (done_count != done_before) begin
      note_mismatch("done pulsed for an aborted instruction");
    end
    drop_expected();
    use_stall = 1'b1;
  endtask

  task automatic run_tests();
    vec_isa_pkg::vop_t     op;
    vec_lane_pkg::vreg_t   rd;
    vec_lane_pkg::vreg_t   ra;
    vec_lane_pkg::vreg_t   rb;
    vec_lane_pkg::elem_t   sv;
    vec_lane_pkg::offset_t len;
    vec_lane_pkg::offset_t first;
    use_stall = 1'b1;
    // broadcast, scalar add on top of it, index pattern
    run_instr(vec_isa_pkg::VMV_VX, 3'd1, 3'd0, 3'd0, 32'h1234_5678, MAX_VL, 0);
    run_instr(vec_isa_pkg::VADD_VX, 3'd2, 3'd0, 3'd1, 32'h0000_1111, MAX_VL, 0);
    run_instr(vec_isa_pkg::VID_V, 3'd3, 3'd0, 3'd0, 32'h0, MAX_VL, 0);
    // vector-vector ops reading earlier results over some partial ranges
    run_instr(vec_isa_pkg::VADD_VV, 3'd4, 3'd2, 3'd3, 32'h0, MAX_VL, 0);
    run_instr(vec_isa_pkg::VSUB_VV, 3'd5, 3'd4, 3'd1, 32'h0, 13, 3);
    run_instr(vec_isa_pkg::VAND_VV, 3'd6, 3'd2, 3'd3, 32'h0, 11, 1);
    run_instr(vec_isa_pkg::VXOR_VV, 3'd7, 3'd5, 3'd6, 32'h0, MAX_VL, 0);
    // empty vector still ends with done
    run_instr(vec_isa_pkg::VADD_VV, 3'd0, 3'd1, 3'd2, 32'h0, 0, 0);
    for (int n = 0; n < 40; n++) begin
      op    = vec_isa_pkg::vop_t'(3'($random(seed)));
      rd    = vec_lane_pkg::vreg_t'($random(seed));
      ra    = vec_lane_pkg::vreg_t'($random(seed));
      rb    = vec_lane_pkg::vreg_t'($random(seed));
      sv    = $random(seed);
      len   = $unsigned($random(seed)) % (MAX_VL + 1);
      first = (len == 0) ? 0 : $unsigned($random(seed)) % len;
      run_instr(op, rd, ra, rb, sv, len, first);
    end
    // known contents, abort, then read the register back through a scalar add of 0
    run_instr(vec_isa_pkg::VID_V, 3'd5, 3'd0, 3'd0, 32'h0, MAX_VL, 0);
    run_clear();
    run_instr(vec_isa_pkg::VADD_VX, 3'd6, 3'd0, 3'd5, 32'h0, MAX_VL, 0);
  endtask

  initial begin : stimulus
    seed           = 54;
    use_stall      = 1'b0;
    timed_out      = 1'b0;
    idle_due       = 1'b0;
    mismatch_count = 0;
    error_count    = 0;
    instr_count    = 0;
    report_count   = 0;
    done_count     = 0;
    nRST           = 1'b0;
    instr_valid    = 1'b0;
    instr          = '0;
    scalar         = '0;
    vl             = '0;
    vstart         = '0;
    stall          = 1'b0;
    clear          = 1'b0;
    model_reset();
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    // quiet after reset
    check_done(done, 1'b0, busy, 1'b0);
    run_tests();
    $display("instructions %0d, reports %0d, mismatches %0d, other errors %0d",
             instr_count, report_count, mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/vector_unit.sv
// vector execution unit top level
module vector_unit #(
  parameter int NUM_LANES = 2,
  parameter int MAX_VL    = 16,
  parameter int NUM_VREGS = 8
) (
  input  logic                                      CLK,
  input  logic                                      nRST,
  input  logic                                      instr_valid,
  input  logic [vec_isa_pkg::INSTR_W-1:0]           instr,
  input  vec_lane_pkg::elem_t                       scalar,
  input  vec_lane_pkg::offset_t                     vl,
  input  vec_lane_pkg::offset_t                     vstart,
  input  logic                                      stall,
  input  logic                                      clear,
  output logic                                      busy,
  output logic                                      wb_valid,
  output vec_lane_pkg::vreg_t                       wb_vd,
  output vec_lane_pkg::offset_t                     wb_offset,
  output logic [NUM_LANES-1:0]                      wb_mask,
  output logic [NUM_LANES*vec_lane_pkg::ELEM_W-1:0] wb_data,
  output logic                                      done
);

  issue_if                       issue ();
  group_if #(.NUM_LANES(NUM_LANES)) group ();

  vec_lane_pkg::offset_t cnt_offset;
  logic                  cnt_active;
  logic                  cnt_done;
  logic                  wr_en;
  vec_lane_pkg::vreg_t   wr_reg;
  vec_lane_pkg::offset_t wr_offset;
  logic [NUM_LANES-1:0]  wr_mask;
  vec_lane_pkg::elem_t   wr_data [NUM_LANES];

  vec_decode decode_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .scalar      (scalar),
    .vl          (vl),
    .vstart      (vstart),
    .clear       (clear),
    .busy        (busy),
    .issue       (issue)
  );

  element_counter #(.NUM_LANES(NUM_LANES)) counter_inst (
    .CLK    (CLK),
    .nRST   (nRST),
    .issue  (issue),
    .stall  (stall),
    .clear  (clear),
    .offset (cnt_offset),
    .active (cnt_active),
    .done   (cnt_done)
  );

  vec_execute #(
    .NUM_LANES (NUM_LANES),
    .MAX_VL    (MAX_VL),
    .NUM_VREGS (NUM_VREGS)
  ) execute_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .offset    (cnt_offset),
    .active    (cnt_active),
    .done      (cnt_done),
    .stall     (stall),
    .group     (group),
    .wr_en     (wr_en),
    .wr_reg    (wr_reg),
    .wr_offset (wr_offset),
    .wr_mask   (wr_mask),
    .wr_data   (wr_data)
  );

  vec_writeback #(.NUM_LANES(NUM_LANES)) writeback_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .group     (group),
    .busy      (busy),
    .wr_en     (wr_en),
    .wr_reg    (wr_reg),
    .wr_offset (wr_offset),
    .wr_mask   (wr_mask),
    .wr_data   (wr_data),
    .wb_valid  (wb_valid),
    .wb_vd     (wb_vd),
    .wb_offset (wb_offset),
    .wb_mask   (wb_mask),
    .wb_data   (wb_data),
    .done      (done)
  );

endmodule

// File: design/vec_writeback.sv
// vector writeback and result report
module vec_writeback #(
  parameter int NUM_LANES = 2
) (
  input  logic                                    CLK,
  input  logic                                    nRST,
  group_if.consumer                               group,
  output logic                                    busy,
  output logic                                    wr_en,
  output vec_lane_pkg::vreg_t                     wr_reg,
  output vec_lane_pkg::offset_t                   wr_offset,
  output logic [NUM_LANES-1:0]                    wr_mask,
  output vec_lane_pkg::elem_t                     wr_data [NUM_LANES],
  output logic                                    wb_valid,
  output vec_lane_pkg::vreg_t                     wb_vd,
  output vec_lane_pkg::offset_t                   wb_offset,
  output logic [NUM_LANES-1:0]                    wb_mask,
  output logic [NUM_LANES*vec_lane_pkg::ELEM_W-1:0] wb_data,
  output logic                                    done
);

  logic [NUM_LANES-1:0] lane_mask;
  vec_lane_pkg::elem_t  data_q [NUM_LANES];

  // lane in range and op actually writes
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_mask[i] = ((group.offset + vec_lane_pkg::offset_t'(i)) < group.vl) &&
                     (group.op != vec_isa_pkg::VNOP);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_valid <= 1'b0;
      wb_mask  <= '0;
      done     <= 1'b0;
    end else begin
      wb_valid <= group.valid;
      wb_mask  <= group.valid ? lane_mask : '0;
      // one pulse, on the last report
      done     <= group.valid & group.last;
    end
  end

  always_ff @(posedge CLK) begin
    if (group.valid) begin
      wb_vd     <= group.vd;
      wb_offset <= group.offset;
      data_q    <= group.results;
    end
  end

  // register file write shares the report registers
  assign wr_en     = wb_valid;
  assign wr_reg    = wb_vd;
  assign wr_offset = wb_offset;
  assign wr_mask   = wb_mask;
  assign wr_data   = data_q;

  // lane 0 in the low word
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_pack
    assign wb_data[g*vec_lane_pkg::ELEM_W +: vec_lane_pkg::ELEM_W] = data_q[g];
  end

  // counter running or a group in either pipe stage
  assign busy = group.pending | group.valid | wb_valid;

endmodule

// File: design/vec_execute.sv
// vector execute stage
module vec_execute #(
  parameter int NUM_LANES = 2,
  parameter int MAX_VL    = 16,
  parameter int NUM_VREGS = 8
) (
  input  logic                  CLK,
  input  logic                  nRST,
  issue_if.executor             issue,
  input  vec_lane_pkg::offset_t offset,
  input  logic                  active,
  input  logic                  done,
  input  logic                  stall,
  group_if.producer             group,
  input  logic                  wr_en,
  input  vec_lane_pkg::vreg_t   wr_reg,
  input  vec_lane_pkg::offset_t wr_offset,
  input  logic [NUM_LANES-1:0]  wr_mask,
  input  vec_lane_pkg::elem_t   wr_data [NUM_LANES]
);

  vec_lane_pkg::elem_t src_a [NUM_LANES];
  vec_lane_pkg::elem_t src_b [NUM_LANES];
  vec_lane_pkg::elem_t lane_res [NUM_LANES];
  logic                issue_grp;

  // vs1 on port a, vs2 on port b
  vec_regfile #(
    .NUM_LANES (NUM_LANES),
    .MAX_VL    (MAX_VL),
    .NUM_VREGS (NUM_VREGS)
  ) regfile_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .rd_reg_a  (issue.vs1),
    .rd_reg_b  (issue.vs2),
    .rd_offset (offset),
    .rd_data_a (src_a),
    .rd_data_b (src_b),
    .wr_en     (wr_en),
    .wr_reg    (wr_reg),
    .wr_offset (wr_offset),
    .wr_mask   (wr_mask),
    .wr_data   (wr_data)
  );

  // a group leaves the counter this cycle
  assign issue_grp = active & ~stall;

  // lane ALUs, all in parallel
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      case (issue.op)
        vec_isa_pkg::VADD_VV: lane_res[i] = src_a[i] + src_b[i];
        vec_isa_pkg::VSUB_VV: lane_res[i] = src_a[i] - src_b[i];
        vec_isa_pkg::VAND_VV: lane_res[i] = src_a[i] & src_b[i];
        vec_isa_pkg::VXOR_VV: lane_res[i] = src_a[i] ^ src_b[i];
        vec_isa_pkg::VADD_VX: lane_res[i] = issue.scalar + src_b[i];
        vec_isa_pkg::VMV_VX:  lane_res[i] = issue.scalar;
        // element index
        vec_isa_pkg::VID_V:   lane_res[i] = offset + vec_lane_pkg::offset_t'(i);
        default:              lane_res[i] = '0;
      endcase
    end
  end

  // keeps busy up while the counter is still running
  assign group.pending = active;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      group.valid <= 1'b0;
      group.last  <= 1'b0;
    end else begin
      group.valid <= issue_grp;
      group.last  <= done;
    end
  end

  // group payload
  always_ff @(posedge CLK) begin
    if (issue_grp) begin
      group.vd      <= issue.vd;
      group.offset  <= offset;
      group.results <= lane_res;
      group.op      <= issue.op;
      group.vl      <= issue.vl;
    end
  end

endmodule

// File: design/element_counter.sv
// vector element counter
module element_counter #(
  parameter int NUM_LANES = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,
  issue_if.counter              issue,
  input  logic                  stall,
  input  logic                  clear,
  output vec_lane_pkg::offset_t offset,
  output logic                  active,
  output logic                  done
);

  logic                       start_reg;
  logic                       ena;
  logic                       final_grp;
  vec_lane_pkg::offset_t      offset_reg;
  vec_lane_pkg::offset_t      next_offset;
  vec_lane_pkg::cnt_state_t   state;

  // running from the start pulse until the final group goes out
  assign ena    = issue.start | start_reg;
  // clear kills issue in the same cycle
  assign active = ena & ~clear;

  // first group uses vstart directly
  assign offset      = issue.start ? issue.vstart : offset_reg;
  assign next_offset = offset + vec_lane_pkg::offset_t'(NUM_LANES);
  // next step would reach vl, so this is the final group
  // also covers vl of 0 with one empty group
  assign final_grp   = next_offset >= issue.vl;
  assign done        = active & ~stall & final_grp;

  // phase of the current group
  always_comb begin
    if (!active) begin
      state = vec_lane_pkg::IDLE;
    end else if (final_grp) begin
      state = vec_lane_pkg::LAST;
    end else begin
      state = vec_lane_pkg::RUN;
    end
  end

  // start flag
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start_reg <= 1'b0;
    end else if (clear | done) begin
      start_reg <= 1'b0;
    end else if (issue.start) begin
      start_reg <= 1'b1;
    end
  end

  // offset steps by one group per unstalled cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset_reg <= '0;
    end else if (clear) begin
      offset_reg <= '0;
    end else if (active & ~stall) begin
      offset_reg <= next_offset;
    end else if (issue.start) begin
      // stalled on the start cycle so vstart is held
      offset_reg <= issue.vstart;
    end
  end

  // stalled run keeps its offset into the next cycle
  assert property (@(posedge CLK) disable iff (!nRST) (active && stall) |=> $stable(offset))
    else $error("offset moved during stall");

  // final group hands the counter back to idle
  assert property (@(posedge CLK) disable iff (!nRST) done |=> state == vec_lane_pkg::IDLE)
    else $error("counter still running after the final group");

endmodule

// File: design/vec_decode.sv
// vector instruction decode
module vec_decode (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              instr_valid,
  input  logic [vec_isa_pkg::INSTR_W-1:0]   instr,
  input  vec_lane_pkg::elem_t               scalar,
  input  vec_lane_pkg::offset_t             vl,
  input  vec_lane_pkg::offset_t             vstart,
  input  logic                              clear,
  input  logic                              busy,
  issue_if.issuer                           issue
);

  logic              accept;
  vec_isa_pkg::vop_t op_dec;

  // take a new instruction only when idle and not aborting
  assign accept = instr_valid & ~busy & ~clear;

  // opcode field to operation, anything unknown runs as a nop
  always_comb begin
    case (instr[vec_isa_pkg::OP_MSB:vec_isa_pkg::OP_LSB])
      3'd0:    op_dec = vec_isa_pkg::VADD_VV;
      3'd1:    op_dec = vec_isa_pkg::VSUB_VV;
      3'd2:    op_dec = vec_isa_pkg::VAND_VV;
      3'd3:    op_dec = vec_isa_pkg::VXOR_VV;
      3'd4:    op_dec = vec_isa_pkg::VADD_VX;
      3'd5:    op_dec = vec_isa_pkg::VMV_VX;
      3'd6:    op_dec = vec_isa_pkg::VID_V;
      default: op_dec = vec_isa_pkg::VNOP;
    endcase
  end

  // start pulses the cycle after acceptance
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      issue.start <= 1'b0;
    end else if (clear) begin
      issue.start <= 1'b0;
    end else begin
      issue.start <= accept;
    end
  end

  // operand capture, held until the next accepted instruction
  always_ff @(posedge CLK) begin
    if (accept) begin
      issue.op     <= op_dec;
      issue.vd     <= instr[vec_isa_pkg::VD_MSB:vec_isa_pkg::VD_LSB];
      issue.vs1    <= instr[vec_isa_pkg::VS1_MSB:vec_isa_pkg::VS1_LSB];
      issue.vs2    <= instr[vec_isa_pkg::VS2_MSB:vec_isa_pkg::VS2_LSB];
      issue.scalar <= scalar;
      issue.vl     <= vl;
      issue.vstart <= vstart;
    end
  end

  // source must hold off while a run is in progress
  assert property (@(posedge CLK) disable iff (!nRST) instr_valid |-> !busy)
    else $error("instruction presented while busy");

endmodule

// File: design/vec_regfile.sv
// vector register file
module vec_regfile #(
  parameter int NUM_LANES = 2,
  parameter int MAX_VL    = 16,
  parameter int NUM_VREGS = 8
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  vec_lane_pkg::vreg_t   rd_reg_a,
  input  vec_lane_pkg::vreg_t   rd_reg_b,
  input  vec_lane_pkg::offset_t rd_offset,
  output vec_lane_pkg::elem_t   rd_data_a [NUM_LANES],
  output vec_lane_pkg::elem_t   rd_data_b [NUM_LANES],
  input  logic                  wr_en,
  input  vec_lane_pkg::vreg_t   wr_reg,
  input  vec_lane_pkg::offset_t wr_offset,
  input  logic [NUM_LANES-1:0]  wr_mask,
  input  vec_lane_pkg::elem_t   wr_data [NUM_LANES]
);

  localparam int IDX_W = (MAX_VL > 1) ? $clog2(MAX_VL) : 1;

  vec_lane_pkg::elem_t   regs [NUM_VREGS][MAX_VL];
  vec_lane_pkg::offset_t rd_idx [NUM_LANES];
  vec_lane_pkg::offset_t wr_idx [NUM_LANES];

  // consecutive elements per lane, zero past the register end
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rd_idx[i] = rd_offset + vec_lane_pkg::offset_t'(i);
      wr_idx[i] = wr_offset + vec_lane_pkg::offset_t'(i);
      if (rd_idx[i] < vec_lane_pkg::offset_t'(MAX_VL)) begin
        rd_data_a[i] = regs[rd_reg_a][rd_idx[i][IDX_W-1:0]];
        rd_data_b[i] = regs[rd_reg_b][rd_idx[i][IDX_W-1:0]];
      end else begin
        rd_data_a[i] = '0;
        rd_data_b[i] = '0;
      end
    end
  end

  // masked lane writes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int v = 0; v < NUM_VREGS; v++) begin
        for (int e = 0; e < MAX_VL; e++) begin
          regs[v][e] <= '0;
        end
      end
    end else if (wr_en) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        // out of range lanes dropped silently
        if (wr_mask[i] && (wr_idx[i] < vec_lane_pkg::offset_t'(MAX_VL))) begin
          regs[wr_reg][wr_idx[i][IDX_W-1:0]] <= wr_data[i];
        end
      end
    end
  end

endmodule

// File: design/vec_ifs.sv
// vector unit internal interfaces

// decoded instruction, held for the whole run
interface issue_if;
  vec_isa_pkg::vop_t    op;
  vec_lane_pkg::vreg_t  vd;
  vec_lane_pkg::vreg_t  vs1;
  vec_lane_pkg::vreg_t  vs2;
  vec_lane_pkg::elem_t  scalar;
  vec_lane_pkg::offset_t vl;
  vec_lane_pkg::offset_t vstart;
  // one cycle pulse
  logic                 start;

  modport issuer (output op, vd, vs1, vs2, scalar, vl, vstart, start);
  // counter only needs the range and the kick
  modport counter (input vl, vstart, start);
  modport executor (input op, vd, vs1, vs2, scalar, vl);
endinterface

// one registered group of lane results
interface group_if #(
  parameter int NUM_LANES = 2
);
  logic                  valid;
  vec_lane_pkg::vreg_t   vd;
  vec_lane_pkg::offset_t offset;
  vec_lane_pkg::elem_t   results [NUM_LANES];
  logic                  last;
  // op and vl ride along for lane masking
  vec_isa_pkg::vop_t     op;
  vec_lane_pkg::offset_t vl;
  // instruction still handing out groups
  logic                  pending;

  modport producer (output valid, vd, offset, results, last, op, vl, pending);
  modport consumer (input valid, vd, offset, results, last, op, vl, pending);
endinterface

// File: design/vec_lane_pkg.sv
// vector lane data types
package vec_lane_pkg;

  // element width, fixed at 32 bits
  localparam int ELEM_W = 32;
  // vector register index width
  localparam int VREG_W = 3;

  // one vector element
  typedef logic [ELEM_W-1:0] elem_t;

  // element offset within a vector register
  typedef logic [31:0] offset_t;

  // vector register index
  typedef logic [VREG_W-1:0] vreg_t;

  // element counter phase
  // RUN while groups remain, LAST on the final group
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    LAST
  } cnt_state_t;

endpackage

// File: design/vec_isa_pkg.sv
// vector instruction set definitions
package vec_isa_pkg;

  // instruction word width
  localparam int INSTR_W = 16;

  // opcode field
  localparam int OP_LSB = 0;
  localparam int OP_MSB = 2;
  // destination register field
  localparam int VD_LSB = 4;
  localparam int VD_MSB = 6;
  // first source register field
  localparam int VS1_LSB = 8;
  localparam int VS1_MSB = 10;
  // second source register field
  localparam int VS2_LSB = 12;
  localparam int VS2_MSB = 14;

  // supported operations, VNOP runs but writes nothing
  typedef enum logic [2:0] {
    VADD_VV = 3'd0,
    VSUB_VV = 3'd1,
    VAND_VV = 3'd2,
    VXOR_VV = 3'd3,
    VADD_VX = 3'd4,
    VMV_VX  = 3'd5,
    VID_V   = 3'd6,
    VNOP    = 3'd7
  } vop_t;

endpackage
